// ==== Makefile ====
SRCS := $(shell cat vlog.f)
SIM  := obj_dir/Vtb_pool_out

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module tb_pool_out -o Vtb_pool_out

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "run failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log || (echo "run ended without result"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== logic/pool_byte_gather.sv ====
// byte gather: collects fifteen bytes per address into one output word
module pool_byte_gather import pool_out_pkg::*; #(
  parameter int ADDR_W = 4
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       byte_valid_i,
  input  byte_beat_t byte_i,
  output logic       byte_ready_o,
  input  logic       flush_i,
  input  logic       full_i,
  output logic       push_o,
  output word_t      word_o,
  output logic       done_o
);

  localparam int NUM_ADDR = 2 ** ADDR_W;

  // ==========================================================================
  // storage
  // ==========================================================================

  // byte slots per address
  logic [DATA_W-1:0] byte_mem [NUM_ADDR][BYTES_PER_WORD];
  lane_cnt_t         cnt_q    [NUM_ADDR];

  logic [ADDR_W-1:0] in_addr;
  lane_cnt_t         in_cnt;
  logic              accept;
  logic              fill_push;

  // flush scan
  logic [ADDR_W-1:0] scan_q;
  logic              done_q;
  logic              scan_busy;
  logic              scan_step;
  logic              flush_push;
  logic              any_pend;

  logic [ADDR_W-1:0] sel_addr;
  lane_cnt_t         sel_cnt;

  assign in_addr = byte_i.addr[ADDR_W-1:0];
  assign in_cnt  = cnt_q[in_addr];

  // input stalls on a full queue and during the scan
  assign byte_ready_o = !full_i && !flush_i;
  assign accept       = byte_valid_i && byte_ready_o;

  // fifteenth byte completes the word on the same edge
  assign fill_push = accept && (in_cnt == lane_cnt_t'(BYTES_PER_WORD - 1));

  always_ff @(posedge clk) begin
    if (accept) begin
      byte_mem[in_addr][in_cnt] <= byte_i.data;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int a = 0; a < NUM_ADDR; a++) begin
        cnt_q[a] <= '0;
      end
    end else if (flush_push) begin
      cnt_q[scan_q] <= '0;
    end else if (fill_push) begin
      cnt_q[in_addr] <= '0;
    end else if (accept) begin
      cnt_q[in_addr] <= in_cnt + lane_cnt_t'(1);
    end
  end

  // ==========================================================================
  // flush scan
  // ==========================================================================

  assign scan_busy = flush_i && !done_q;

  // empty addresses are skipped, a filled one waits for queue room
  assign scan_step  = (cnt_q[scan_q] == '0) || !full_i;
  assign flush_push = scan_busy && (cnt_q[scan_q] != '0) && !full_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      scan_q <= '0;
      done_q <= 1'b0;
    end else if (!flush_i) begin
      scan_q <= '0;
      done_q <= 1'b0;
    end else if (scan_busy && scan_step) begin
      if (scan_q == {ADDR_W{1'b1}}) begin
        done_q <= 1'b1;
      end else begin
        scan_q <= scan_q + 1'b1;
      end
    end
  end

  assign done_o = done_q;

  // some address still holds bytes
  always_comb begin
    any_pend = 1'b0;
    for (int a = 0; a < NUM_ADDR; a++) begin
      if (cnt_q[a] != '0) begin
        any_pend = 1'b1;
      end
    end
  end

  // ==========================================================================
  // word assembly
  // ==========================================================================

  assign sel_addr = flush_i ? scan_q : in_addr;
  assign sel_cnt  = cnt_q[sel_addr];

  // address in lane 0, stored bytes after it, unfilled lanes zero
  always_comb begin
    word_o = '0;
    word_o[DATA_W-1:0] = DATA_W'(sel_addr);
    for (int j = 0; j < BYTES_PER_WORD; j++) begin
      if (j < int'(sel_cnt)) begin
        word_o[(j+1)*DATA_W +: DATA_W] = byte_mem[sel_addr][j];
      end else if (!flush_i && j == int'(sel_cnt)) begin
        // incoming byte lands straight in the word
        word_o[(j+1)*DATA_W +: DATA_W] = byte_i.data;
      end
    end
  end

  assign push_o = fill_push || flush_push;

  // a finished scan leaves no address holding bytes
  a_done_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    done_o |-> !any_pend
  );

endmodule

// ==== logic/pool_flag_packer.sv ====
// flag packer: four flags per output word, zero padded on a layer flush
module pool_flag_packer import pool_out_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flag_valid_i,
  input  flag_beat_t flag_i,
  output logic       flag_ready_o,
  input  logic       flush_i,
  input  logic       full_i,
  output logic       push_o,
  output word_t      word_o,
  output logic       empty_o
);

  logic [1:0] fill_q;
  flag_beat_t hold_q [FLAGS_PER_WORD-1];

  logic accept;
  logic group_push;
  logic flush_push;

  assign flag_ready_o = !full_i && !flush_i;
  assign accept       = flag_valid_i && flag_ready_o;

  assign group_push = accept && (fill_q == 2'd3);
  assign flush_push = flush_i && (fill_q != 2'd0) && !full_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fill_q <= '0;
    end else if (flush_push) begin
      fill_q <= '0;
    end else if (accept) begin
      // wraps to zero on the fourth flag
      fill_q <= fill_q + 2'd1;
    end
  end

  // earlier flags of the group
  always_ff @(posedge clk) begin
    if (accept && fill_q != 2'd3) begin
      hold_q[fill_q] <= flag_i;
    end
  end

  // oldest flag in the low bits
  always_comb begin
    word_o = '0;
    for (int k = 0; k < FLAGS_PER_WORD - 1; k++) begin
      if (k < int'(fill_q)) begin
        word_o[k*FLAG_W +: FLAG_W] = hold_q[k];
      end
    end
    if (accept) begin
      word_o[(FLAGS_PER_WORD-1)*FLAG_W +: FLAG_W] = flag_i;
    end
  end

  assign push_o  = group_push || flush_push;
  assign empty_o = (fill_q == 2'd0);

endmodule

// ==== logic/pool_layer_ctrl.sv ====
// layer controller: runs the end-of-layer flush and pulses clear when drained
module pool_layer_ctrl import pool_out_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic layer_fnh_i,
  input  logic gather_done_i,
  input  logic packer_empty_i,
  input  logic data_empty_i,
  input  logic flag_empty_i,
  output logic flush_o,
  output logic clear_up_o
);

  flush_state_t state_q;
  flush_state_t state_d;

  // ==========================================================================
  // next state
  // ==========================================================================

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_RUN: begin
        if (layer_fnh_i) begin
          state_d = ST_FLUSH;
        end
      end
      ST_FLUSH: begin
        // scan finished and no partial flag group left
        if (gather_done_i && packer_empty_i) begin
          state_d = ST_DRAIN;
        end
      end
      ST_DRAIN: begin
        if (data_empty_i && flag_empty_i) begin
          state_d = ST_CLEAR;
        end
      end
      ST_CLEAR: begin
        state_d = ST_RUN;
      end
      default: begin
        state_d = ST_RUN;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  // ==========================================================================
  // outputs
  // ==========================================================================

  assign flush_o    = (state_q == ST_FLUSH);
  assign clear_up_o = (state_q == ST_CLEAR);

  // layer finish arrives as a one-cycle pulse
  a_fnh_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    layer_fnh_i |=> !layer_fnh_i
  );

endmodule

// ==== logic/pool_out_pkg.sv ====
// pooling output stage: shared widths, word and beat types, flush states
package pool_out_pkg;

  // ==========================================================================
  // widths
  // ==========================================================================

  // one pooled result
  localparam int DATA_W = 8;

  // one flag value
  localparam int FLAG_W = 32;

  // byte lanes in an output word, lane 0 carries the address
  localparam int LANES = 16;
  localparam int BYTES_PER_WORD = LANES - 1;

  // flags packed into one output word
  localparam int FLAGS_PER_WORD = 4;

  localparam int WORD_W = LANES * DATA_W;

  // ==========================================================================
  // types
  // ==========================================================================

  // fill count per address, never reaches 15 in storage
  typedef logic [3:0] lane_cnt_t;

  typedef logic [WORD_W-1:0] word_t;

  // input byte with its destination address
  typedef struct packed {
    logic [7:0]        addr;
    logic [DATA_W-1:0] data;
  } byte_beat_t;

  typedef logic [FLAG_W-1:0] flag_beat_t;

  // layer finish sequence
  typedef enum logic [1:0] {
    ST_RUN   = 2'd0,
    ST_FLUSH = 2'd1,
    ST_DRAIN = 2'd2,
    ST_CLEAR = 2'd3
  } flush_state_t;

endpackage

// ==== logic/pool_out_top.sv ====
// pooling output stage top: gather, flag packer, two word FIFOs, layer control
module pool_out_top import pool_out_pkg::*; #(
  parameter int ADDR_W     = 4,
  parameter int FIFO_DEPTH = 8
) (
  input  logic       clk,
  input  logic       rst_n,

  // pooled bytes
  input  logic       byte_valid_i,
  input  byte_beat_t byte_i,
  output logic       byte_ready_o,

  // flags
  input  logic       flag_valid_i,
  input  flag_beat_t flag_i,
  output logic       flag_ready_o,

  // data words out
  output logic       data_valid_o,
  output word_t      data_o,
  input  logic       data_ready_i,

  // flag words out
  output logic       flgw_valid_o,
  output word_t      flgw_o,
  input  logic       flgw_ready_i,

  input  logic       layer_fnh_i,
  output logic       clear_up_o
);

  logic  flush;
  logic  gather_done;
  logic  packer_empty;

  logic  data_push;
  word_t data_word;
  logic  data_full;
  logic  data_empty;

  logic  flag_push;
  word_t flag_word;
  logic  flag_full;
  logic  flag_empty;

  pool_byte_gather #(
    .ADDR_W (ADDR_W)
  ) u_gather (
    .clk          (clk),
    .rst_n        (rst_n),
    .byte_valid_i (byte_valid_i),
    .byte_i       (byte_i),
    .byte_ready_o (byte_ready_o),
    .flush_i      (flush),
    .full_i       (data_full),
    .push_o       (data_push),
    .word_o       (data_word),
    .done_o       (gather_done)
  );

  pool_flag_packer u_packer (
    .clk          (clk),
    .rst_n        (rst_n),
    .flag_valid_i (flag_valid_i),
    .flag_i       (flag_i),
    .flag_ready_o (flag_ready_o),
    .flush_i      (flush),
    .full_i       (flag_full),
    .push_o       (flag_push),
    .word_o       (flag_word),
    .empty_o      (packer_empty)
  );

  pool_word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_data_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (data_push),
    .word_i  (data_word),
    .full_o  (data_full),
    .valid_o (data_valid_o),
    .word_o  (data_o),
    .ready_i (data_ready_i),
    .empty_o (data_empty)
  );

  pool_word_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_flag_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (flag_push),
    .word_i  (flag_word),
    .full_o  (flag_full),
    .valid_o (flgw_valid_o),
    .word_o  (flgw_o),
    .ready_i (flgw_ready_i),
    .empty_o (flag_empty)
  );

  pool_layer_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .layer_fnh_i    (layer_fnh_i),
    .gather_done_i  (gather_done),
    .packer_empty_i (packer_empty),
    .data_empty_i   (data_empty),
    .flag_empty_i   (flag_empty),
    .flush_o        (flush),
    .clear_up_o     (clear_up_o)
  );

endmodule

// ==== logic/pool_word_fifo.sv ====
// show-ahead word FIFO with a valid/ready drain port
module pool_word_fifo import pool_out_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  push_i,
  input  word_t word_i,
  output logic  full_o,
  output logic  valid_o,
  output word_t word_o,
  input  logic  ready_i,
  output logic  empty_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  word_t            mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             pop;

  assign pop = valid_o && ready_i;

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= word_i;
    end
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop);
    end
  end

  assign full_o  = (count_q == (PTR_W+1)'(FIFO_DEPTH));
  assign empty_o = (count_q == '0);
  assign valid_o = !empty_o;

  // head entry visible without a read strobe
  assign word_o = mem[rd_ptr_q];

  // producers stall on full, so an overflow means a lost word
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    push_i |-> !full_o
  );

endmodule

// ==== tb/tb_pool_out.sv ====
// testbench for the pooling output stage, table driven against a reference model
module tb_pool_out import pool_out_pkg::*; ();

  localparam int ADDR_W     = 4;
  localparam int FIFO_DEPTH = 8;
  localparam int NUM_ADDR   = 2 ** ADDR_W;
  // generous bound on cycles spent in any one row
  localparam int ROW_CYCLES = 64;

  typedef enum logic [1:0] {K_BYTE, K_FLAG, K_FINISH, K_STALL} kind_t;

  // stall_exp marks a row whose input must meet ready low
  typedef struct packed {
    kind_t       kind;
    logic [31:0] value;
    logic        data_rdy;
    logic        flgw_rdy;
    logic        stall_exp;
  } row_t;

  logic       clk;
  logic       rst_n;
  logic       byte_valid_i;
  byte_beat_t byte_i;
  logic       byte_ready_o;
  logic       flag_valid_i;
  flag_beat_t flag_i;
  logic       flag_ready_o;
  logic       data_valid_o;
  word_t      data_o;
  logic       data_ready_i;
  logic       flgw_valid_o;
  word_t      flgw_o;
  logic       flgw_ready_i;
  logic       layer_fnh_i;
  logic       clear_up_o;

  row_t              rows [$];
  word_t             exp_data [$];
  word_t             exp_flgw [$];
  flag_beat_t        pend_flags [$];
  logic [DATA_W-1:0] pend_bytes [NUM_ADDR][BYTES_PER_WORD];
  int                pend_cnt [NUM_ADDR] = '{default: 0};
  int                clear_cnt;
  int                finish_cnt;
  logic [31:0]       seed;

  pool_out_top #(
    .ADDR_W     (ADDR_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (.*);

  // ==========================================================================
  // reference model
  // ==========================================================================

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic logic [31:0] byte_val(input int a, input logic [7:0] d);
    return {16'h0, 8'(a), d};
  endfunction

  // address in lane 0, bytes in arrival order, rest zero
  function automatic word_t data_word(input int a);
    word_t w;
    w = '0;
    w[DATA_W-1:0] = DATA_W'(a);
    for (int k = 0; k < pend_cnt[a]; k++) begin
      w[(k+1)*DATA_W +: DATA_W] = pend_bytes[a][k];
    end
    return w;
  endfunction

  // oldest flag lowest, missing flags zero
  function automatic word_t flag_word();
    word_t w;
    w = '0;
    foreach (pend_flags[k]) begin
      w[k*FLAG_W +: FLAG_W] = pend_flags[k];
    end
    return w;
  endfunction

  task automatic model_byte(input byte_beat_t b);
    int a;
    a = int'(b.addr) % NUM_ADDR;
    pend_bytes[a][pend_cnt[a]] = b.data;
    pend_cnt[a]++;
    if (pend_cnt[a] == BYTES_PER_WORD) begin
      exp_data.push_back(data_word(a));
      pend_cnt[a] = 0;
    end
  endtask

  task automatic model_flag(input flag_beat_t f);
    pend_flags.push_back(f);
    if (pend_flags.size() == FLAGS_PER_WORD) begin
      exp_flgw.push_back(flag_word());
      pend_flags.delete();
    end
  endtask

  // flush emits partial addresses in ascending order
  task automatic model_finish();
    for (int a = 0; a < NUM_ADDR; a++) begin
      if (pend_cnt[a] != 0) begin
        exp_data.push_back(data_word(a));
        pend_cnt[a] = 0;
      end
    end
    if (pend_flags.size() != 0) begin
      exp_flgw.push_back(flag_word());
      pend_flags.delete();
    end
  endtask

  task automatic check(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  // ==========================================================================
  // stimulus table
  // ==========================================================================

  task automatic add_row(input kind_t k, input logic [31:0] v, input logic dr,
                         input logic fr, input logic st);
    row_t r;
    r = '{k, v, dr, fr, st};
    rows.push_back(r);
  endtask

  task automatic build_table();
    // one full address, then one flag group
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      add_row(K_BYTE, byte_val(5, 8'(8'h30 + i)), 1'b1, 1'b1, 1'b0);
    end
    for (int i = 0; i < FLAGS_PER_WORD; i++) begin
      add_row(K_FLAG, 32'hf1a9_0000 + 32'(i), 1'b1, 1'b1, 1'b0);
    end
    add_row(K_STALL, 32'd8, 1'b1, 1'b1, 1'b0);
    // back-pressure, outputs held off until the last input stalls
    for (int i = 0; i <= FIFO_DEPTH * FLAGS_PER_WORD; i++) begin
      seed = next_rand(seed);
      add_row(K_FLAG, seed, 1'b0, 1'b0, i == FIFO_DEPTH * FLAGS_PER_WORD);
    end
    for (int i = 0; i <= FIFO_DEPTH * BYTES_PER_WORD; i++) begin
      seed = next_rand(seed);
      add_row(K_BYTE, byte_val(i / BYTES_PER_WORD, seed[7:0]), 1'b0, 1'b0,
              i == FIFO_DEPTH * BYTES_PER_WORD);
    end
    add_row(K_STALL, 32'd20, 1'b1, 1'b1, 1'b0);
    // partial addresses and a partial flag group before a layer finish
    for (int i = 0; i < 12; i++) begin
      add_row(K_BYTE, byte_val(i < 4 ? 12 : (i < 11 ? 3 : 0), 8'(8'hc0 + i)), 1'b1, 1'b1,
              1'b0);
    end
    add_row(K_FLAG, 32'h0bad_0001, 1'b1, 1'b1, 1'b0);
    add_row(K_FLAG, 32'h0bad_0002, 1'b1, 1'b1, 1'b0);
    add_row(K_FINISH, 32'd0, 1'b1, 1'b1, 1'b0);
    // random mix with ready toggling, closed by a flush
    for (int i = 0; i < 300; i++) begin
      seed = next_rand(seed);
      if (seed[1:0] == 2'd3) begin
        add_row(K_STALL, 32'(seed[4:2]) + 32'd1, seed[30], seed[31], 1'b0);
      end else if (seed[1:0] == 2'd2) begin
        add_row(K_FLAG, seed, seed[30], seed[31], 1'b0);
      end else begin
        add_row(K_BYTE, byte_val(int'(seed[11:8]), seed[23:16]), seed[30], seed[31], 1'b0);
      end
    end
    add_row(K_FINISH, 32'd0, 1'b1, 1'b1, 1'b0);
  endtask

  // ==========================================================================
  // clock, driver, monitor, watchdog
  // ==========================================================================

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    row_t r;
    logic stalled;
    rst_n        = 1'b0;
    byte_valid_i = 1'b0;
    byte_i       = '0;
    flag_valid_i = 1'b0;
    flag_i       = '0;
    data_ready_i = 1'b0;
    flgw_ready_i = 1'b0;
    layer_fnh_i  = 1'b0;
    clear_cnt    = 0;
    finish_cnt   = 0;
    seed         = 32'h7f83_7918;
    build_table();
    repeat (10) @(negedge clk);
    // outputs idle while reset is held
    check("data_valid_o", word_t'(data_valid_o), word_t'(0));
    check("flgw_valid_o", word_t'(flgw_valid_o), word_t'(0));
    check("clear_up_o", word_t'(clear_up_o), word_t'(0));
    check("byte_ready_o", word_t'(byte_ready_o), word_t'(1));
    check("flag_ready_o", word_t'(flag_ready_o), word_t'(1));
    rst_n = 1'b1;
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      stalled = 1'b0;
      @(negedge clk);
      byte_valid_i = 1'b0;
      flag_valid_i = 1'b0;
      data_ready_i = r.data_rdy;
      flgw_ready_i = r.flgw_rdy;
      case (r.kind)
        K_BYTE: begin
          byte_valid_i = 1'b1;
          byte_i = r.value[15:0];
          // a stalled input opens both output ports so the queues drain
          while (!byte_ready_o) begin
            stalled = 1'b1;
            data_ready_i = 1'b1;
            flgw_ready_i = 1'b1;
            @(negedge clk);
          end
          model_byte(byte_i);
        end
        K_FLAG: begin
          flag_valid_i = 1'b1;
          flag_i = r.value;
          while (!flag_ready_o) begin
            stalled = 1'b1;
            data_ready_i = 1'b1;
            flgw_ready_i = 1'b1;
            @(negedge clk);
          end
          model_flag(flag_i);
        end
        K_FINISH: begin
          layer_fnh_i = 1'b1;
          finish_cnt++;
          model_finish();
          @(negedge clk);
          layer_fnh_i = 1'b0;
          while (!clear_up_o) begin
            @(negedge clk);
          end
        end
        default: begin
          repeat (r.value) @(negedge clk);
        end
      endcase
      if (r.stall_exp) begin
        check("input ready stall seen", word_t'(stalled), word_t'(1));
      end
    end
    @(negedge clk);
    byte_valid_i = 1'b0;
    flag_valid_i = 1'b0;
    data_ready_i = 1'b1;
    flgw_ready_i = 1'b1;
    repeat (4 * FIFO_DEPTH) @(negedge clk);
    if (exp_data.size() != 0 || exp_flgw.size() != 0) begin
      fail_run("expected words were never received");
    end else begin
      check("clear_up_o pulse count", word_t'(clear_cnt), word_t'(finish_cnt));
      $display("Simulation finished: PASS");
      $finish;
    end
  end

  // output handshakes pop the expected queues
  always @(posedge clk) begin
    if (rst_n) begin
      if (data_valid_o && data_ready_i) begin
        if (exp_data.size() == 0) begin
          fail_run("a data word came out with none expected");
        end else begin
          check("data_o", data_o, exp_data.pop_front());
        end
      end
      if (flgw_valid_o && flgw_ready_i) begin
        if (exp_flgw.size() == 0) begin
          fail_run("a flag word came out with none expected");
        end else begin
          check("flgw_o", flgw_o, exp_flgw.pop_front());
        end
      end
      if (clear_up_o) begin
        clear_cnt++;
        if (exp_data.size() != 0 || exp_flgw.size() != 0) begin
          fail_run("clear_up_o pulsed before all words were received");
        end
      end
    end
  end

  initial begin
    @(posedge rst_n);
    repeat (rows.size() * ROW_CYCLES) @(posedge clk);
    fail_run("timeout, the stimulus table did not complete in time");
  end

endmodule

// ==== vlog.f ====
logic/pool_out_pkg.sv
logic/pool_byte_gather.sv
logic/pool_flag_packer.sv
logic/pool_word_fifo.sv
logic/pool_layer_ctrl.sv
logic/pool_out_top.sv
tb/tb_pool_out.sv
